// File: Makefile
VERILATOR  ?= verilator
TOP        := udp_echo_tb
FILELIST   := all.f
VFLAGS     := --timing --assert
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_TEXT  := All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation result: pass"; \
	else \
		echo "Simulation result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: all.f
source/udp_echo_pkg.sv
source/udp_rx_filter.sv
source/udp_payload_fifo.sv
source/udp_reply_builder.sv
source/udp_echo_core.sv
testbench/udp_echo_tb.sv

// File: source/udp_echo_core.sv
// ##########################################################
// UDP echo core: filter, payload FIFO and reply builder
// ##########################################################

module udp_echo_core import udp_echo_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,

    // Received UDP frames
    input  udp_rx_hdr_t          rx_hdr,
    input  logic                 rx_hdr_valid,
    output logic                 rx_hdr_ready,
    input  payload_beat_t        rx_payload,
    input  logic                 rx_payload_valid,
    output logic                 rx_payload_ready,

    // Reply frames
    output udp_tx_hdr_t          tx_hdr,
    output logic                 tx_hdr_valid,
    input  logic                 tx_hdr_ready,
    output payload_beat_t        tx_payload,
    output logic                 tx_payload_valid,
    input  logic                 tx_payload_ready,

    output logic [LED_WIDTH-1:0] led
);

    // Filter to builder
    udp_rx_hdr_t   match_hdr;
    logic          match_hdr_valid;
    logic          match_hdr_ready;

    // Filter to FIFO
    payload_beat_t fifo_in;
    logic          fifo_in_valid;
    logic          fifo_in_ready;

    // FIFO to builder
    payload_beat_t fifo_out;
    logic          fifo_out_valid;
    logic          fifo_out_ready;

    udp_rx_filter filter_i (
        .clk              (clk),
        .rst              (rst),
        .rx_hdr           (rx_hdr),
        .rx_hdr_valid     (rx_hdr_valid),
        .rx_hdr_ready     (rx_hdr_ready),
        .rx_payload       (rx_payload),
        .rx_payload_valid (rx_payload_valid),
        .rx_payload_ready (rx_payload_ready),
        .match_hdr        (match_hdr),
        .match_hdr_valid  (match_hdr_valid),
        .match_hdr_ready  (match_hdr_ready),
        .fifo_in          (fifo_in),
        .fifo_in_valid    (fifo_in_valid),
        .fifo_in_ready    (fifo_in_ready)
    );

    udp_payload_fifo fifo_i (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (fifo_in),
        .in_valid  (fifo_in_valid),
        .in_ready  (fifo_in_ready),
        .out_beat  (fifo_out),
        .out_valid (fifo_out_valid),
        .out_ready (fifo_out_ready)
    );

    udp_reply_builder builder_i (
        .clk              (clk),
        .rst              (rst),
        .match_hdr        (match_hdr),
        .match_hdr_valid  (match_hdr_valid),
        .match_hdr_ready  (match_hdr_ready),
        .fifo_out         (fifo_out),
        .fifo_out_valid   (fifo_out_valid),
        .fifo_out_ready   (fifo_out_ready),
        .tx_hdr           (tx_hdr),
        .tx_hdr_valid     (tx_hdr_valid),
        .tx_hdr_ready     (tx_hdr_ready),
        .tx_payload       (tx_payload),
        .tx_payload_valid (tx_payload_valid),
        .tx_payload_ready (tx_payload_ready),
        .led              (led)
    );

endmodule

// File: source/udp_echo_pkg.sv
// ##########################################################
// Constants, widths and shared types of the UDP echo core
// Received and reply header structs, payload beat struct
// ##########################################################

package udp_echo_pkg;

    // Port that gets turned back to the sender
    localparam logic [15:0] ECHO_PORT = 16'd1234;

    // Header field widths
    localparam int IP_WIDTH     = 32;
    localparam int PORT_WIDTH   = 16;
    localparam int LENGTH_WIDTH = 16;

    // Payload beat layout
    localparam int DATA_WIDTH = 64;
    localparam int KEEP_WIDTH = 8;

    // Payload buffer size, one entry per beat
    localparam int FIFO_DEPTH      = 16;
    localparam int FIFO_ADDR_WIDTH = 4;

    // Status display
    localparam int LED_WIDTH = 8;

    // Header of a received UDP frame, as handed over by the stack
    typedef struct packed {
        logic [IP_WIDTH-1:0]     source_ip;
        logic [PORT_WIDTH-1:0]   source_port;
        logic [PORT_WIDTH-1:0]   dest_port;
        logic [LENGTH_WIDTH-1:0] length;
    } udp_rx_hdr_t;

    // Header of a reply frame
    // TTL, DSCP/ECN, checksum and source IP are filled in downstream
    typedef struct packed {
        logic [IP_WIDTH-1:0]     dest_ip;
        logic [PORT_WIDTH-1:0]   source_port;
        logic [PORT_WIDTH-1:0]   dest_port;
        logic [LENGTH_WIDTH-1:0] length;
    } udp_tx_hdr_t;

    // One beat of frame payload
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        // Byte enables, bit 0 for the low byte
        logic [KEEP_WIDTH-1:0] keep;
        // Final beat of the frame
        logic                  last;
        // Error mark from upstream, carried along untouched
        logic                  user;
    } payload_beat_t;

endpackage

// File: source/udp_payload_fifo.sv
// ##########################################################
// Circular buffer for payload beats of echoed frames
// ##########################################################

module udp_payload_fifo import udp_echo_pkg::*; (
    input  logic          clk,
    input  logic          rst,

    // Write side
    input  payload_beat_t in_beat,
    input  logic          in_valid,
    output logic          in_ready,

    // Read side
    output payload_beat_t out_beat,
    output logic          out_valid,
    input  logic          out_ready
);

    payload_beat_t              mem [FIFO_DEPTH];
    logic [FIFO_ADDR_WIDTH-1:0] wr_ptr;
    logic [FIFO_ADDR_WIDTH-1:0] rd_ptr;
    logic [FIFO_ADDR_WIDTH:0]   count;
    logic                       wr_en;
    logic                       rd_en;

    // Count is one bit wider so full and empty stay apart
    assign in_ready  = (count != (FIFO_ADDR_WIDTH+1)'(FIFO_DEPTH));
    assign out_valid = (count != '0);

    assign wr_en = in_valid && in_ready;
    assign rd_en = out_valid && out_ready;

    // Head entry shown directly, visible the cycle after its write
    assign out_beat = mem[rd_ptr];

    // Storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_beat;
        end
    end

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({wr_en, rd_en})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    // Simultaneous read and write, level unchanged
                    count <= count;
                end
            endcase
        end
    end

endmodule

// File: source/udp_reply_builder.sv
// ##########################################################
// Reply builder: registered reply header, payload output
// and LED register holding the first byte of each reply
// ##########################################################

module udp_reply_builder import udp_echo_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,

    // Headers of echoed frames
    input  udp_rx_hdr_t          match_hdr,
    input  logic                 match_hdr_valid,
    output logic                 match_hdr_ready,

    // Buffered payload
    input  payload_beat_t        fifo_out,
    input  logic                 fifo_out_valid,
    output logic                 fifo_out_ready,

    // Reply frames
    output udp_tx_hdr_t          tx_hdr,
    output logic                 tx_hdr_valid,
    input  logic                 tx_hdr_ready,
    output payload_beat_t        tx_payload,
    output logic                 tx_payload_valid,
    input  logic                 tx_payload_ready,

    output logic [LED_WIDTH-1:0] led
);

    udp_tx_hdr_t          hdr_reg;
    logic                 hdr_valid_reg;
    logic                 hdr_load;
    logic                 beat_xfer;
    logic                 sof_reg;
    logic [LED_WIDTH-1:0] led_reg;

    // Single slot, free when empty or leaving this cycle
    assign match_hdr_ready = !hdr_valid_reg || tx_hdr_ready;
    assign hdr_load        = match_hdr_valid && match_hdr_ready;

    // Reply goes back to the sender with the ports swapped
    always_ff @(posedge clk) begin
        if (hdr_load) begin
            hdr_reg.dest_ip     <= match_hdr.source_ip;
            hdr_reg.source_port <= match_hdr.dest_port;
            hdr_reg.dest_port   <= match_hdr.source_port;
            hdr_reg.length      <= match_hdr.length;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_valid_reg <= 1'b0;
        end else if (hdr_load) begin
            hdr_valid_reg <= 1'b1;
        end else if (tx_hdr_ready) begin
            hdr_valid_reg <= 1'b0;
        end
    end

    assign tx_hdr       = hdr_reg;
    assign tx_hdr_valid = hdr_valid_reg;

    // Payload leaves straight from the FIFO head
    assign tx_payload       = fifo_out;
    assign tx_payload_valid = fifo_out_valid;
    assign fifo_out_ready   = tx_payload_ready;

    assign beat_xfer = tx_payload_valid && tx_payload_ready;

    // Start of frame follows the beat after each last
    always_ff @(posedge clk) begin
        if (rst) begin
            sof_reg <= 1'b1;
        end else if (beat_xfer) begin
            sof_reg <= tx_payload.last;
        end
    end

    // First payload byte of each reply onto the LEDs
    always_ff @(posedge clk) begin
        if (rst) begin
            led_reg <= '0;
        end else if (beat_xfer && sof_reg) begin
            led_reg <= tx_payload.data[LED_WIDTH-1:0];
        end
    end

    assign led = led_reg;

endmodule

// File: source/udp_rx_filter.sv
// ##########################################################
// Receive filter: port match on each UDP header
// Echoed frames go on to builder and FIFO, others are dropped
// ##########################################################

module udp_rx_filter import udp_echo_pkg::*; (
    input  logic          clk,
    input  logic          rst,

    // Received frames
    input  udp_rx_hdr_t   rx_hdr,
    input  logic          rx_hdr_valid,
    output logic          rx_hdr_ready,
    input  payload_beat_t rx_payload,
    input  logic          rx_payload_valid,
    output logic          rx_payload_ready,

    // Headers of echoed frames, towards the reply builder
    output udp_rx_hdr_t   match_hdr,
    output logic          match_hdr_valid,
    input  logic          match_hdr_ready,

    // Payload of echoed frames, towards the FIFO
    output payload_beat_t fifo_in,
    output logic          fifo_in_valid,
    input  logic          fifo_in_ready
);

    typedef enum logic [1:0] {
        FRAME_IDLE,
        FRAME_ECHO,
        FRAME_DROP
    } frame_state_t;

    frame_state_t state;
    logic         hdr_match;
    logic         hdr_xfer;
    logic         last_xfer;

    // The only place where the echo port is compared
    assign hdr_match = (rx_hdr.dest_port == ECHO_PORT);

    // Headers only taken between frames
    always_comb begin
        if (state == FRAME_IDLE) begin
            rx_hdr_ready = hdr_match ? match_hdr_ready : 1'b1;
        end else begin
            rx_hdr_ready = 1'b0;
        end
    end

    assign match_hdr       = rx_hdr;
    assign match_hdr_valid = (state == FRAME_IDLE) && rx_hdr_valid && hdr_match;

    // Dropped beats are swallowed at full rate
    assign rx_payload_ready = ((state == FRAME_ECHO) && fifo_in_ready) ||
                              (state == FRAME_DROP);

    assign fifo_in       = rx_payload;
    assign fifo_in_valid = (state == FRAME_ECHO) && rx_payload_valid;

    assign hdr_xfer  = rx_hdr_valid && rx_hdr_ready;
    assign last_xfer = rx_payload_valid && rx_payload_ready && rx_payload.last;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FRAME_IDLE;
        end else begin
            case (state)
                FRAME_IDLE: begin
                    if (hdr_xfer) begin
                        state <= hdr_match ? FRAME_ECHO : FRAME_DROP;
                    end
                end
                FRAME_ECHO, FRAME_DROP: begin
                    // Frame ends with its last beat
                    if (last_xfer) begin
                        state <= FRAME_IDLE;
                    end
                end
                default: begin
                    state <= FRAME_IDLE;
                end
            endcase
        end
    end

endmodule

// File: testbench/udp_echo_tb.sv
// ##########################################################
// Testbench for the UDP echo core: random frames, reply
// scoreboard, LED and stall checks by assertions
// ##########################################################

module udp_echo_tb import udp_echo_pkg::*; ();

    localparam int          CLK_PERIOD   = 8;
    localparam logic [15:0] LFSR_SEED    = 16'd31183;
    localparam int          N_BASIC      = 4;
    localparam int          N_MIXED      = 6;
    localparam int          N_STRESS     = 40;
    localparam int          FRAME_BUDGET = 200;
    localparam int          TOTAL_FRAMES = N_BASIC + N_MIXED + N_STRESS;

    logic                 clk = 1'b0;
    logic                 rst;
    udp_rx_hdr_t          rx_hdr;
    logic                 rx_hdr_valid;
    logic                 rx_hdr_ready;
    payload_beat_t        rx_payload;
    logic                 rx_payload_valid;
    logic                 rx_payload_ready;
    udp_tx_hdr_t          tx_hdr;
    logic                 tx_hdr_valid;
    logic                 tx_hdr_ready;
    payload_beat_t        tx_payload;
    logic                 tx_payload_valid;
    logic                 tx_payload_ready;
    logic [LED_WIDTH-1:0] led;

    logic [15:0]          lfsr_state = LFSR_SEED;
    logic                 stall_mode = 1'b0;
    int                   error_count = 0;
    int                   tests_run = 0;
    int                   tests_failed = 0;

    // Expected replies, in the order the frames were sent
    udp_tx_hdr_t          exp_hdr_q[$];
    payload_beat_t        exp_beat_q[$];
    logic                 tb_sof = 1'b1;
    logic                 led_check = 1'b0;
    logic [LED_WIDTH-1:0] led_expect;

    always #(CLK_PERIOD / 2) clk = ~clk;

    udp_echo_core dut_i (
        .clk              (clk),
        .rst              (rst),
        .rx_hdr           (rx_hdr),
        .rx_hdr_valid     (rx_hdr_valid),
        .rx_hdr_ready     (rx_hdr_ready),
        .rx_payload       (rx_payload),
        .rx_payload_valid (rx_payload_valid),
        .rx_payload_ready (rx_payload_ready),
        .tx_hdr           (tx_hdr),
        .tx_hdr_valid     (tx_hdr_valid),
        .tx_hdr_ready     (tx_hdr_ready),
        .tx_payload       (tx_payload),
        .tx_payload_valid (tx_payload_valid),
        .tx_payload_ready (tx_payload_ready),
        .led              (led)
    );

    // Galois LFSR, taps for a maximal 16-bit sequence
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit handed out
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic report_error(input string msg);
        error_count++;
        $display("ERR %0t: %s", $time, msg);
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("test %-12s ok", name);
        end else begin
            tests_failed++;
            $display("test %-12s FAILED with %0d errors", name, error_count - errors_before);
        end
    endtask

    // Source holds its valids low for a few cycles now and then
    task automatic idle_cycles();
        int n;
        n = 0;
        if (take_bits(2) == 0) begin
            n = 1 + int'(take_bits(2));
        end
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_frame(input logic echo);
        udp_rx_hdr_t   hdr;
        udp_tx_hdr_t   reply;
        payload_beat_t beat;
        int            n_beats;
        hdr.source_ip   = 32'(take_bits(32));
        hdr.source_port = 16'(take_bits(16));
        hdr.length      = 16'(take_bits(16));
        if (echo) begin
            hdr.dest_port = ECHO_PORT;
        end else begin
            hdr.dest_port = 16'(take_bits(16));
            if (hdr.dest_port == ECHO_PORT) begin
                hdr.dest_port = ~ECHO_PORT;
            end
        end
        n_beats = 1 + int'(take_bits(3)) % 6;
        // Reply goes to the sender, ports swapped, length kept
        if (echo) begin
            reply.dest_ip     = hdr.source_ip;
            reply.source_port = hdr.dest_port;
            reply.dest_port   = hdr.source_port;
            reply.length      = hdr.length;
            exp_hdr_q.push_back(reply);
        end
        idle_cycles();
        rx_hdr       = hdr;
        rx_hdr_valid = 1'b1;
        do @(posedge clk); while (!rx_hdr_ready);
        #1;
        rx_hdr_valid = 1'b0;
        for (int i = 0; i < n_beats; i++) begin
            beat.data = take_bits(64);
            beat.keep = 8'(take_bits(8));
            beat.last = (i == n_beats - 1);
            beat.user = 1'(take_bits(1));
            if (echo) begin
                exp_beat_q.push_back(beat);
            end
            idle_cycles();
            rx_payload       = beat;
            rx_payload_valid = 1'b1;
            do @(posedge clk); while (!rx_payload_ready);
            #1;
            rx_payload_valid = 1'b0;
        end
    endtask

    task automatic wait_drain();
        while (exp_hdr_q.size() != 0 || exp_beat_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        #1;
    endtask

    // Reply sink, long random stalls on both channels in stall mode
    initial begin : drive_sink
        int hdr_left;
        int pay_left;
        hdr_left         = 0;
        pay_left         = 0;
        tx_hdr_ready     = 1'b0;
        tx_payload_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (!stall_mode) begin
                tx_hdr_ready     = 1'b1;
                tx_payload_ready = 1'b1;
            end else begin
                if (hdr_left == 0) begin
                    tx_hdr_ready = 1'(take_bits(1));
                    hdr_left = tx_hdr_ready ? 1 + int'(take_bits(3)) : 1 + int'(take_bits(5));
                end
                if (pay_left == 0) begin
                    tx_payload_ready = 1'(take_bits(1));
                    pay_left = tx_payload_ready ? 1 + int'(take_bits(3)) : 1 + int'(take_bits(5));
                end
                hdr_left--;
                pay_left--;
            end
        end
    end

    // Scoreboard and LED monitor
    always @(posedge clk) begin
        if (rst) begin
            tb_sof    = 1'b1;
            led_check = 1'b0;
        end else begin
            if (led_check) begin
                assert (led == led_expect)
                    else report_error($sformatf("led %02h, expected %02h", led, led_expect));
            end
            led_check = 1'b0;
            if (tx_hdr_valid) begin
                assert (exp_hdr_q.size() != 0)
                    else report_error("reply header with no echoed frame pending");
            end
            if (tx_payload_valid) begin
                assert (exp_beat_q.size() != 0)
                    else report_error("reply beat with no echoed beat pending");
            end
            if (tx_hdr_valid && tx_hdr_ready && exp_hdr_q.size() != 0) begin
                assert (tx_hdr == exp_hdr_q[0])
                    else report_error($sformatf("reply header %h, expected %h",
                                                tx_hdr, exp_hdr_q[0]));
                exp_hdr_q.delete(0);
            end
            if (tx_payload_valid && tx_payload_ready && exp_beat_q.size() != 0) begin
                assert (tx_payload == exp_beat_q[0])
                    else report_error($sformatf("reply beat %h, expected %h",
                                                tx_payload, exp_beat_q[0]));
                // LED shows the low byte of the first beat sent in each echoed frame
                if (tb_sof) begin
                    led_expect = exp_beat_q[0].data[LED_WIDTH-1:0];
                    led_check  = 1'b1;
                end
                tb_sof = exp_beat_q[0].last;
                exp_beat_q.delete(0);
            end
        end
    end

    // Stalled replies hold still until taken
    assert property (@(posedge clk) disable iff (rst)
        tx_hdr_valid && !tx_hdr_ready |=> tx_hdr_valid && $stable(tx_hdr))
        else report_error("reply header changed or dropped before its transfer");

    assert property (@(posedge clk) disable iff (rst)
        tx_payload_valid && !tx_payload_ready |=> tx_payload_valid && $stable(tx_payload))
        else report_error("reply beat changed or dropped before its transfer");

    initial begin : watchdog
        #(TOTAL_FRAMES * FRAME_BUDGET * CLK_PERIOD);
        $display("Timeout after %0d cycles, %0d reply headers and %0d reply beats never came out",
                 TOTAL_FRAMES * FRAME_BUDGET, exp_hdr_q.size(), exp_beat_q.size());
        $display("Test failures found");
        $finish;
    end

    initial begin : run_tests
        int errors_before;
        rst              = 1'b1;
        rx_hdr           = '0;
        rx_hdr_valid     = 1'b0;
        rx_payload       = '0;
        rx_payload_valid = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        // Quiet outputs after reset
        errors_before = error_count;
        repeat (2) @(posedge clk);
        #1;
        assert (!tx_hdr_valid && !tx_payload_valid)
            else report_error("reply valid raised after reset with no input");
        assert (led == '0)
            else report_error($sformatf("led %02h after reset, expected 00", led));
        end_test("reset_idle", errors_before);

        errors_before = error_count;
        for (int i = 0; i < N_BASIC; i++) begin
            send_frame(1'b1);
        end
        wait_drain();
        end_test("echo", errors_before);

        // Two dropped frames before each echoed one
        errors_before = error_count;
        for (int i = 0; i < N_MIXED; i++) begin
            send_frame(i % 3 == 2);
        end
        wait_drain();
        end_test("drop_mix", errors_before);

        errors_before = error_count;
        stall_mode = 1'b1;
        for (int i = 0; i < N_STRESS; i++) begin
            send_frame(1'(take_bits(1)));
        end
        wait_drain();
        stall_mode = 1'b0;
        end_test("stall_stress", errors_before);

        $display("tests run %0d, failing %0d, errors %0d", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
